// ==== hdl/tcdm_pkg.sv ====
// shared widths and control type of the TCDM subsystem
// addresses are word addresses; bank = add mod NB_CHAN, row = add / NB_CHAN
// low_prio_max_stall of 0 disables the stall escape

package tcdm_pkg;

  // word payload
  localparam int unsigned DATA_W = 32;
  localparam int unsigned BE_W   = DATA_W / 8;  // one enable per byte

  // word address, not byte address
  localparam int unsigned ADDR_W = 16;

  // width of the stall limit and of the counter that tracks it
  localparam int unsigned STALL_W = 8;

  // interconnect control, held static by the system for the
  // duration of a transfer burst
  typedef struct packed {
    logic               hwpe_prio;           // 1: accelerator side wins the banks
    logic [STALL_W-1:0] low_prio_max_stall;  // contention cycles before one escape
  } tcdm_ctrl_t;

endpackage : tcdm_pkg

// ==== hdl/tcdm_mem_if.sv ====
// single-word memory channel, req/gnt handshake
// accepted when req && gnt; master holds req and payload until then
// read data (wen = 1) valid exactly one cycle after acceptance

interface tcdm_mem_if;
  import tcdm_pkg::*;

  logic              req;     // access request
  logic              gnt;     // accepted this cycle
  logic [ADDR_W-1:0] add;     // word address
  logic              wen;     // 1 = read, 0 = write
  logic [BE_W-1:0]   be;      // byte enables, writes only
  logic [DATA_W-1:0] data;    // write data
  logic [DATA_W-1:0] r_data;  // read data, one cycle after gnt

  // requester side
  modport master (
    output req,
    output add,
    output wen,
    output be,
    output data,
    input  gnt,
    input  r_data
  );

  // memory side
  modport slave (
    input  req,
    input  add,
    input  wen,
    input  be,
    input  data,
    output gnt,
    output r_data
  );

endinterface : tcdm_mem_if

// ==== hdl/tcdm_banks.sv ====
// NB_CHAN single-port SRAM banks, BANK_ROWS words each
// every request is accepted (gnt = req); writes land at the clock edge
// read data registered, valid one cycle after the accept
// address bits above the row field are ignored, rows wrap

module tcdm_banks #(
  parameter int unsigned NB_CHAN   = 4,
  parameter int unsigned BANK_ROWS = 64
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  tcdm_mem_if.slave mem [NB_CHAN-1:0]
);
  import tcdm_pkg::*;

  localparam int unsigned BANK_SEL_W = $clog2(NB_CHAN);    // bank bits of add
  localparam int unsigned ROW_W      = $clog2(BANK_ROWS);  // row bits above them

  for (genvar b = 0; b < NB_CHAN; b++) begin : gen_bank
    logic [DATA_W-1:0] store [BANK_ROWS];  // bank storage
    logic [ROW_W-1:0]  row;
    logic [DATA_W-1:0] rdata_q;

    assign row          = mem[b].add[BANK_SEL_W +: ROW_W];
    assign mem[b].gnt   = mem[b].req;  // no internal conflicts
    assign mem[b].r_data = rdata_q;

    // byte-enabled write
    always_ff @(posedge clk_i)
    begin
      if (mem[b].req && !mem[b].wen)
      begin
        for (int i = 0; i < BE_W; i++)
          if (mem[b].be[i])
            store[row][8*i +: 8] <= mem[b].data[8*i +: 8];
      end
    end

    // read port, holds last value between reads
    always_ff @(posedge clk_i or negedge rst_ni)
    begin
      if (!rst_ni)
        rdata_q <= '0;
      else if (mem[b].req && mem[b].wen)
        rdata_q <= store[row];
    end
  end

endmodule : tcdm_banks

// ==== hdl/core_log_xbar.sv ====
// core-side crossbar, one word access per core per cycle
// per bank the lowest-numbered requesting core wins; others retry
// request path is combinational, so core_gnt is seen in the accept cycle
// core_r_valid pulses one cycle after an accepted read

module core_log_xbar #(
  parameter int unsigned NB_CHAN = 4,
  parameter int unsigned NB_CORE = 2
) (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  logic [NB_CORE-1:0]                       core_req,
  output logic [NB_CORE-1:0]                       core_gnt,
  input  logic [NB_CORE-1:0][tcdm_pkg::ADDR_W-1:0] core_add,
  input  logic [NB_CORE-1:0]                       core_wen,
  input  logic [NB_CORE-1:0][tcdm_pkg::BE_W-1:0]   core_be,
  input  logic [NB_CORE-1:0][tcdm_pkg::DATA_W-1:0] core_data,
  output logic [NB_CORE-1:0][tcdm_pkg::DATA_W-1:0] core_r_data,
  output logic [NB_CORE-1:0]                       core_r_valid,
  tcdm_mem_if.master                               out [NB_CHAN-1:0]
);
  import tcdm_pkg::*;

  localparam int unsigned BANK_IDX_W = (NB_CHAN > 1) ? $clog2(NB_CHAN) : 1;
  localparam int unsigned CORE_IDX_W = (NB_CORE > 1) ? $clog2(NB_CORE) : 1;

  logic [NB_CORE-1:0][BANK_IDX_W-1:0] core_bank;   // target bank per core
  logic [NB_CHAN-1:0]                 sel_valid;   // some core wins this bank
  logic [NB_CHAN-1:0][CORE_IDX_W-1:0] sel_idx;     // winning core per bank
  logic [NB_CHAN-1:0]                 bank_gnt;
  logic [NB_CHAN-1:0][DATA_W-1:0]     bank_rdata;
  logic [NB_CHAN-1:0]                 rd_accept;   // read accepted this cycle
  logic [NB_CHAN-1:0]                 rd_valid_q;  // read data arrives now
  logic [NB_CHAN-1:0][CORE_IDX_W-1:0] rd_idx_q;    // who owns that data

  // bank decode and per-bank fixed priority
  always_comb
  begin
    sel_valid = '0;
    sel_idx   = '0;
    for (int c = 0; c < NB_CORE; c++)
      core_bank[c] = BANK_IDX_W'(core_add[c] % NB_CHAN);  // low address bits
    for (int b = 0; b < NB_CHAN; b++)
    begin
      // walk downwards so the lowest index is written last
      for (int c = NB_CORE - 1; c >= 0; c--)
      begin
        if (core_req[c] && core_bank[c] == BANK_IDX_W'(b))
        begin
          sel_valid[b] = 1'b1;
          sel_idx[b]   = CORE_IDX_W'(c);
        end
      end
    end
  end

  // drive the bank channels with the winner's payload
  for (genvar b = 0; b < NB_CHAN; b++) begin : gen_bank
    assign out[b].req    = sel_valid[b];
    assign out[b].add    = core_add[sel_idx[b]];
    assign out[b].wen    = core_wen[sel_idx[b]];
    assign out[b].be     = core_be[sel_idx[b]];
    assign out[b].data   = core_data[sel_idx[b]];
    assign bank_gnt[b]   = out[b].gnt;     // flatten for loop access
    assign bank_rdata[b] = out[b].r_data;
    assign rd_accept[b]  = sel_valid[b] & bank_gnt[b] & core_wen[sel_idx[b]];
  end

  // grant only reaches the selected core
  always_comb
  begin
    core_gnt = '0;
    for (int b = 0; b < NB_CHAN; b++)
      if (sel_valid[b] && bank_gnt[b])
        core_gnt[sel_idx[b]] = 1'b1;
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      rd_valid_q <= '0;
    else
      rd_valid_q <= rd_accept;
  end

  always_ff @(posedge clk_i)
  begin
    rd_idx_q <= sel_idx;  // only meaningful where rd_valid_q is set
  end

  // steer returning data; each core has at most one read in flight
  always_comb
  begin
    core_r_valid = '0;
    core_r_data  = '0;
    for (int b = 0; b < NB_CHAN; b++)
    begin
      if (rd_valid_q[b])
      begin
        core_r_valid[rd_idx_q[b]] = 1'b1;
        core_r_data[rd_idx_q[b]]  = bank_rdata[b];
      end
    end
  end

endmodule : core_log_xbar

// ==== hdl/hwpe_wide_splitter.sv ====
// accelerator port splitter, one wide access of NB_CHAN words
// hwpe_add must be aligned to NB_CHAN words; word k always maps to bank k
// words are granted independently, hwpe_gnt pulses with the last one
// hwpe_r_valid follows hwpe_gnt by one cycle for reads

module hwpe_wide_splitter #(
  parameter int unsigned NB_CHAN = 4
) (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  logic                                     hwpe_req,
  output logic                                     hwpe_gnt,
  input  logic [tcdm_pkg::ADDR_W-1:0]              hwpe_add,
  input  logic                                     hwpe_wen,
  input  logic [NB_CHAN-1:0][tcdm_pkg::BE_W-1:0]   hwpe_be,
  input  logic [NB_CHAN-1:0][tcdm_pkg::DATA_W-1:0] hwpe_data,
  output logic [NB_CHAN-1:0][tcdm_pkg::DATA_W-1:0] hwpe_r_data,
  output logic                                     hwpe_r_valid,
  tcdm_mem_if.master                               out [NB_CHAN-1:0]
);
  import tcdm_pkg::*;

  logic [NB_CHAN-1:0]             done_q;       // words already granted
  logic [NB_CHAN-1:0]             word_gnt;     // words granted this cycle
  logic [NB_CHAN-1:0]             rd_q;         // read data lands this cycle
  logic [NB_CHAN-1:0][DATA_W-1:0] bank_rdata;
  logic [NB_CHAN-1:0][DATA_W-1:0] r_data_q;     // words collected so far
  logic                           r_valid_q;
  logic [ADDR_W-1:0]              base_add;     // first word of the access

  assign base_add = ADDR_W'((hwpe_add / NB_CHAN) * NB_CHAN);  // drop bank bits

  for (genvar k = 0; k < NB_CHAN; k++) begin : gen_word
    assign out[k].req    = hwpe_req & ~done_q[k];  // only words still pending
    assign out[k].add    = base_add + ADDR_W'(k);
    assign out[k].wen    = hwpe_wen;
    assign out[k].be     = hwpe_be[k];
    assign out[k].data   = hwpe_data[k];
    assign word_gnt[k]   = out[k].req & out[k].gnt;
    assign bank_rdata[k] = out[k].r_data;
    // last word's data arrives in the r_valid cycle itself, bypass it
    assign hwpe_r_data[k] = rd_q[k] ? bank_rdata[k] : r_data_q[k];
  end

  // whole access done once every word is in
  assign hwpe_gnt     = hwpe_req & (&(done_q | word_gnt));
  assign hwpe_r_valid = r_valid_q;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      done_q    <= '0;
      rd_q      <= '0;
      r_valid_q <= 1'b0;
    end
    else
    begin
      if (hwpe_gnt)
        done_q <= '0;               // ready for the next access
      else
        done_q <= done_q | word_gnt;
      rd_q      <= hwpe_wen ? word_gnt : '0;
      r_valid_q <= hwpe_gnt & hwpe_wen;
    end
  end

  // capture each word as its bank returns it
  always_ff @(posedge clk_i)
  begin
    for (int k = 0; k < NB_CHAN; k++)
      if (rd_q[k])
        r_data_q[k] <= bank_rdata[k];
  end

endmodule : hwpe_wide_splitter

// ==== hdl/hci_shallow_interconnect.sv ====
// per-bank mux between core side (in_high) and accelerator side (in_low)
// winner is the core side unless ctrl_i.hwpe_prio is set
// losing side passes once after low_prio_max_stall contention cycles
// request path is combinational; read data goes to both sides, each
// side tracks its own grants

module hci_shallow_interconnect #(
  parameter int unsigned NB_CHAN = 4
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  tcdm_pkg::tcdm_ctrl_t ctrl_i,
  tcdm_mem_if.slave            in_high [NB_CHAN-1:0],
  tcdm_mem_if.slave            in_low  [NB_CHAN-1:0],
  tcdm_mem_if.master           out     [NB_CHAN-1:0]
);
  import tcdm_pkg::*;

  logic [NB_CHAN-1:0] high_req;   // core side requests per bank
  logic [NB_CHAN-1:0] low_req;    // accelerator side requests per bank
  logic [NB_CHAN-1:0] win_req;    // requests of the preferred side
  logic [NB_CHAN-1:0] lose_req;   // requests of the other side
  logic [NB_CHAN-1:0] win_pass;   // preferred side owns the bank
  logic [NB_CHAN-1:0] pass_high;  // in_high owns the bank
  logic               win_any;
  logic               lose_any;
  logic               escape;     // give the losing side this cycle
  logic [STALL_W-1:0] stall_q;    // consecutive contention cycles

  for (genvar b = 0; b < NB_CHAN; b++) begin : gen_req
    assign high_req[b] = in_high[b].req;
    assign low_req[b]  = in_low[b].req;
  end

  // swap sides when the accelerator has priority
  assign win_req  = ctrl_i.hwpe_prio ? low_req  : high_req;
  assign lose_req = ctrl_i.hwpe_prio ? high_req : low_req;

  assign escape   = (ctrl_i.low_prio_max_stall != '0) &&
                    (stall_q >= ctrl_i.low_prio_max_stall);
  assign win_any  = (|win_req) & ~escape;  // escape mutes the winner everywhere
  assign lose_any = |lose_req;

  // count contention, restart on the escape cycle or when it ends
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      stall_q <= '0;
    else if (win_any && lose_any)
      stall_q <= stall_q + 1'b1;  // wraps harmlessly when escape is off
    else
      stall_q <= '0;
  end

  for (genvar b = 0; b < NB_CHAN; b++) begin : gen_bind
    // winner takes a bank only where it actually requests
    assign win_pass[b]  = win_any & win_req[b];
    assign pass_high[b] = win_pass[b] ^ ctrl_i.hwpe_prio;  // map back to a port

    assign out[b].req  = pass_high[b] ? in_high[b].req  : in_low[b].req;
    assign out[b].add  = pass_high[b] ? in_high[b].add  : in_low[b].add;
    assign out[b].wen  = pass_high[b] ? in_high[b].wen  : in_low[b].wen;
    assign out[b].be   = pass_high[b] ? in_high[b].be   : in_low[b].be;
    assign out[b].data = pass_high[b] ? in_high[b].data : in_low[b].data;

    // only the passed side sees the grant
    assign in_high[b].gnt = pass_high[b] & out[b].gnt;
    assign in_low[b].gnt  = ~pass_high[b] & out[b].gnt;

    // broadcast, the requesters know which data is theirs
    assign in_high[b].r_data = out[b].r_data;
    assign in_low[b].r_data  = out[b].r_data;
  end

endmodule : hci_shallow_interconnect

// ==== hdl/tcdm_subsystem_top.sv ====
// TCDM subsystem: NB_CORE cores and one wide accelerator port share
// NB_CHAN word-interleaved banks, bank = add mod NB_CHAN
// hwpe_add must be aligned to NB_CHAN words
// ctrl selects side priority and the stall escape

module tcdm_subsystem_top #(
  parameter int unsigned NB_CHAN   = 4,
  parameter int unsigned NB_CORE   = 2,
  parameter int unsigned BANK_ROWS = 64
) (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  // core side
  input  logic [NB_CORE-1:0]                       core_req,
  output logic [NB_CORE-1:0]                       core_gnt,
  input  logic [NB_CORE-1:0][tcdm_pkg::ADDR_W-1:0] core_add,
  input  logic [NB_CORE-1:0]                       core_wen,
  input  logic [NB_CORE-1:0][tcdm_pkg::BE_W-1:0]   core_be,
  input  logic [NB_CORE-1:0][tcdm_pkg::DATA_W-1:0] core_data,
  output logic [NB_CORE-1:0][tcdm_pkg::DATA_W-1:0] core_r_data,
  output logic [NB_CORE-1:0]                       core_r_valid,
  // accelerator side, one word per bank
  input  logic                                     hwpe_req,
  output logic                                     hwpe_gnt,
  input  logic [tcdm_pkg::ADDR_W-1:0]              hwpe_add,
  input  logic                                     hwpe_wen,
  input  logic [NB_CHAN-1:0][tcdm_pkg::BE_W-1:0]   hwpe_be,
  input  logic [NB_CHAN-1:0][tcdm_pkg::DATA_W-1:0] hwpe_data,
  output logic [NB_CHAN-1:0][tcdm_pkg::DATA_W-1:0] hwpe_r_data,
  output logic                                     hwpe_r_valid,
  // interconnect control
  input  tcdm_pkg::tcdm_ctrl_t                     ctrl
);

  tcdm_mem_if xbar_ch [NB_CHAN-1:0] ();  // cores to interconnect
  tcdm_mem_if hwpe_ch [NB_CHAN-1:0] ();  // accelerator to interconnect
  tcdm_mem_if bank_ch [NB_CHAN-1:0] ();  // interconnect to banks

  core_log_xbar #(
    .NB_CHAN (NB_CHAN),
    .NB_CORE (NB_CORE)
  ) core_log_xbar_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .core_req     (core_req),
    .core_gnt     (core_gnt),
    .core_add     (core_add),
    .core_wen     (core_wen),
    .core_be      (core_be),
    .core_data    (core_data),
    .core_r_data  (core_r_data),
    .core_r_valid (core_r_valid),
    .out          (xbar_ch)
  );

  hwpe_wide_splitter #(
    .NB_CHAN (NB_CHAN)
  ) hwpe_wide_splitter_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .hwpe_req     (hwpe_req),
    .hwpe_gnt     (hwpe_gnt),
    .hwpe_add     (hwpe_add),
    .hwpe_wen     (hwpe_wen),
    .hwpe_be      (hwpe_be),
    .hwpe_data    (hwpe_data),
    .hwpe_r_data  (hwpe_r_data),
    .hwpe_r_valid (hwpe_r_valid),
    .out          (hwpe_ch)
  );

  hci_shallow_interconnect #(
    .NB_CHAN (NB_CHAN)
  ) hci_shallow_interconnect_inst (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .ctrl_i  (ctrl),
    .in_high (xbar_ch),
    .in_low  (hwpe_ch),
    .out     (bank_ch)
  );

  tcdm_banks #(
    .NB_CHAN   (NB_CHAN),
    .BANK_ROWS (BANK_ROWS)
  ) tcdm_banks_inst (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .mem    (bank_ch)
  );

endmodule : tcdm_subsystem_top

// ==== sim/tb_tcdm_subsystem.sv ====
// directed testbench for the TCDM subsystem, default parameters
// shadow array models memory by bank and row; addresses stay below
// NB_CHAN*BANK_ROWS so rows never wrap
// inputs change 1 unit after posedge, outputs sampled at negedge

module tb_tcdm_subsystem;
  import tcdm_pkg::*;

  localparam int NB_CHAN   = 4;
  localparam int NB_CORE   = 2;
  localparam int BANK_ROWS = 64;
  localparam int TIMEOUT   = 200;  // cycles per wait

  // what wait_for watches
  localparam int SIG_CORE_GNT    = 0;
  localparam int SIG_CORE_RVALID = 1;
  localparam int SIG_HWPE_GNT    = 2;
  localparam int SIG_HWPE_RVALID = 3;

  logic                               clk_i = 1'b0;
  logic                               rst_ni;
  logic [NB_CORE-1:0]                 core_req;
  logic [NB_CORE-1:0]                 core_gnt;
  logic [NB_CORE-1:0][ADDR_W-1:0]     core_add;
  logic [NB_CORE-1:0]                 core_wen;
  logic [NB_CORE-1:0][BE_W-1:0]       core_be;
  logic [NB_CORE-1:0][DATA_W-1:0]     core_data;
  logic [NB_CORE-1:0][DATA_W-1:0]     core_r_data;
  logic [NB_CORE-1:0]                 core_r_valid;
  logic                               hwpe_req;
  logic                               hwpe_gnt;
  logic [ADDR_W-1:0]                  hwpe_add;
  logic                               hwpe_wen;
  logic [NB_CHAN-1:0][BE_W-1:0]       hwpe_be;
  logic [NB_CHAN-1:0][DATA_W-1:0]     hwpe_data;
  logic [NB_CHAN-1:0][DATA_W-1:0]     hwpe_r_data;
  logic                               hwpe_r_valid;
  tcdm_ctrl_t                         ctrl;

  logic [DATA_W-1:0] shadow [NB_CHAN][BANK_ROWS];  // reference memory
  string             test_name;
  int                errors   = 0;
  int                pass_cnt = 0;
  int                fail_cnt = 0;
  int                cyc      = 0;  // cycle stamp, used for grant order

  tcdm_subsystem_top tcdm_subsystem_top_inst (.*);

  always #2 clk_i = ~clk_i;

  always @(posedge clk_i)
    cyc <= cyc + 1;

  // bank = add mod NB_CHAN, row = add / NB_CHAN, byte merge
  function automatic void model_write(input int add, input logic [BE_W-1:0] be,
                                      input logic [DATA_W-1:0] data);
    for (int i = 0; i < BE_W; i++)
      if (be[i])
        shadow[add % NB_CHAN][add / NB_CHAN][8*i +: 8] = data[8*i +: 8];
  endfunction

  function automatic logic [DATA_W-1:0] model_read(input int add);
    return shadow[add % NB_CHAN][add / NB_CHAN];
  endfunction

  function automatic logic probe(input int sig, input int idx);
    case (sig)
      SIG_CORE_GNT:    return core_gnt[idx];
      SIG_CORE_RVALID: return core_r_valid[idx];
      SIG_HWPE_GNT:    return hwpe_gnt;
      default:         return hwpe_r_valid;
    endcase
  endfunction

  task automatic next_cycle();
    @(posedge clk_i);
    #1;  // drive point
  endtask

  task automatic report_failure(input string what);
    $display("%s: %s", test_name, what);
    errors++;
  endtask

  task automatic check_word(input logic [DATA_W-1:0] exp, input logic [DATA_W-1:0] act);
    if (act !== exp)
    begin
      $display("[ERROR] %s: expected %08h, actual %08h", test_name, exp, act);
      errors++;
    end
  endtask

  task automatic check_cycle(input string what, input int exp, input int act);
    if (act != exp)
    begin
      $display("[ERROR] %s: %s expected in cycle %0d, actual cycle %0d",
               test_name, what, exp, act);
      errors++;
    end
  endtask

  // samples mid-cycle, returns at the next drive point; at = -1 on timeout
  task automatic wait_for(input int sig, input int idx, input string what, output int at,
                          output logic [DATA_W-1:0] word,
                          output logic [NB_CHAN-1:0][DATA_W-1:0] wide);
    at   = -1;
    word = '0;
    wide = '0;
    for (int n = 0; n < TIMEOUT && at < 0; n++)
    begin
      @(negedge clk_i);
      if (probe(sig, idx))
      begin
        at   = cyc;
        word = core_r_data[idx];  // read data is stable here
        wide = hwpe_r_data;
      end
      next_cycle();
    end
    if (at < 0)
      report_failure($sformatf("timed out waiting for %s of port %0d", what, idx));
  endtask

  task automatic core_access(input int c, input int add, input logic wen,
                             input logic [BE_W-1:0] be, input logic [DATA_W-1:0] data,
                             output logic [DATA_W-1:0] rdata, output int at);
    logic [NB_CHAN-1:0][DATA_W-1:0] wide;
    int                             rv;
    core_add[c]  = ADDR_W'(add);
    core_wen[c]  = wen;
    core_be[c]   = be;
    core_data[c] = data;
    core_req[c]  = 1'b1;  // held until granted
    wait_for(SIG_CORE_GNT, c, "core grant", at, rdata, wide);
    core_req[c] = 1'b0;
    if (at >= 0 && !wen)
      model_write(add, be, data);
    if (at >= 0 && wen)
    begin
      wait_for(SIG_CORE_RVALID, c, "core read data", rv, rdata, wide);
      if (rv >= 0)
        check_cycle("core read data", at + 1, rv);  // one cycle after the accept
    end
  endtask

  task automatic hwpe_access(input int add, input logic wen,
                             input logic [NB_CHAN-1:0][BE_W-1:0] be,
                             input logic [NB_CHAN-1:0][DATA_W-1:0] data,
                             output logic [NB_CHAN-1:0][DATA_W-1:0] rdata, output int at);
    logic [DATA_W-1:0] word;
    int                rv;
    hwpe_add  = ADDR_W'(add);  // aligned to NB_CHAN words
    hwpe_wen  = wen;
    hwpe_be   = be;
    hwpe_data = data;
    hwpe_req  = 1'b1;
    wait_for(SIG_HWPE_GNT, 0, "accelerator grant", at, word, rdata);
    hwpe_req = 1'b0;
    if (at >= 0 && !wen)
      for (int k = 0; k < NB_CHAN; k++)
        model_write(add + k, be[k], data[k]);  // word k lands in bank k
    if (at >= 0 && wen)
    begin
      wait_for(SIG_HWPE_RVALID, 0, "accelerator read data", rv, word, rdata);
      if (rv >= 0)
        check_cycle("accelerator read data", at + 1, rv);  // after the last word
    end
  endtask

  task automatic finish_test(input int err0);
    if (errors == err0)
    begin
      pass_cnt++;
      $display("%s: ok", test_name);
    end
    else
    begin
      fail_cnt++;
      $display("%s: %0d errors", test_name, errors - err0);
    end
  endtask

  task automatic core_rw();
    int                err0;
    int                adds [8];
    int                at;
    logic [DATA_W-1:0] rd;
    test_name = "core_rw";
    err0      = errors;
    for (int i = 0; i < 8; i++)
    begin
      adds[i] = int'($urandom % 64);  // rows 0..15
      core_access(i % NB_CORE, adds[i], 1'b0, '1, $urandom, rd, at);  // full word first
      core_access(i % NB_CORE, adds[i], 1'b0, BE_W'($urandom), $urandom, rd, at);
    end
    for (int i = 0; i < 8; i++)
    begin
      core_access((i + 1) % NB_CORE, adds[i], 1'b1, '0, '0, rd, at);  // other core reads
      check_word(model_read(adds[i]), rd);
    end
    finish_test(err0);
  endtask

  task automatic core_conflict();
    int                err0;
    int                g0;
    int                g1;
    logic [DATA_W-1:0] r0;
    logic [DATA_W-1:0] r1;
    test_name = "core_conflict";
    err0      = errors;
    // rows 20 and 21 of bank 2, same cycle
    fork
      core_access(0, 82, 1'b0, '1, $urandom, r0, g0);
      core_access(1, 86, 1'b0, '1, $urandom, r1, g1);
    join
    if (g1 <= g0)
      report_failure("core 1 write was not granted after core 0");
    fork
      core_access(0, 82, 1'b1, '0, '0, r0, g0);
      core_access(1, 86, 1'b1, '0, '0, r1, g1);
    join
    if (g1 <= g0)
      report_failure("core 1 read was not granted after core 0");
    check_word(model_read(82), r0);
    check_word(model_read(86), r1);
    finish_test(err0);
  endtask

  task automatic hwpe_rw();
    int                             err0;
    int                             at;
    logic [DATA_W-1:0]              rd;
    logic [NB_CHAN-1:0][DATA_W-1:0] wd;
    logic [NB_CHAN-1:0][DATA_W-1:0] rw;
    test_name = "hwpe_rw";
    err0      = errors;
    for (int k = 0; k < NB_CHAN; k++)
      wd[k] = $urandom;
    hwpe_access(40, 1'b0, '1, wd, rw, at);  // row 10 of every bank
    for (int k = 0; k < NB_CHAN; k++)
    begin
      core_access(k % NB_CORE, 40 + k, 1'b1, '0, '0, rd, at);
      check_word(model_read(40 + k), rd);
    end
    core_access(0, 41, 1'b0, 4'b0011, $urandom, rd, at);  // low half only
    core_access(1, 42, 1'b0, 4'b1100, $urandom, rd, at);
    hwpe_access(40, 1'b1, '0, '0, rw, at);
    for (int k = 0; k < NB_CHAN; k++)
      check_word(model_read(40 + k), rw[k]);
    finish_test(err0);
  endtask

  task automatic stall_escape();
    int                             err0;
    int                             at;
    logic [DATA_W-1:0]              cd;
    logic [DATA_W-1:0]              rd;
    logic [NB_CHAN-1:0][DATA_W-1:0] wd;
    logic [NB_CHAN-1:0][DATA_W-1:0] rw;
    test_name = "stall_escape";
    err0      = errors;
    cd        = $urandom;
    for (int k = 0; k < NB_CHAN; k++)
      wd[k] = $urandom;
    ctrl         = '0;
    core_add[0]  = ADDR_W'(40);  // bank 0, row 10, rewritten every cycle
    core_wen[0]  = 1'b0;
    core_be[0]   = '1;
    core_data[0] = cd;
    core_req[0]  = 1'b1;
    hwpe_add     = ADDR_W'(80);  // row 20, word 0 fights core 0
    hwpe_wen     = 1'b0;
    hwpe_be      = '1;
    hwpe_data    = wd;
    hwpe_req     = 1'b1;
    for (int n = 0; n < 40; n++)
    begin
      @(negedge clk_i);
      if (hwpe_gnt)
        report_failure("accelerator granted while the escape was off");
      next_cycle();
    end
    ctrl.low_prio_max_stall = 8'd5;
    wait_for(SIG_HWPE_GNT, 0, "accelerator grant", at, rd, rw);
    hwpe_req    = 1'b0;
    core_req[0] = 1'b0;
    ctrl        = '0;
    model_write(40, '1, cd);
    if (at >= 0)
      for (int k = 0; k < NB_CHAN; k++)
        model_write(80 + k, '1, wd[k]);
    hwpe_access(80, 1'b1, '0, '0, rw, at);
    for (int k = 0; k < NB_CHAN; k++)
      check_word(model_read(80 + k), rw[k]);
    core_access(1, 40, 1'b1, '0, '0, rd, at);
    check_word(model_read(40), rd);
    finish_test(err0);
  endtask

  task automatic hwpe_priority();
    int                             err0;
    int                             gh;
    int                             g0;
    int                             g1;
    logic [DATA_W-1:0]              r0;
    logic [DATA_W-1:0]              r1;
    logic [NB_CHAN-1:0][DATA_W-1:0] wd;
    logic [NB_CHAN-1:0][DATA_W-1:0] rw;
    test_name = "hwpe_priority";
    err0      = errors;
    for (int k = 0; k < NB_CHAN; k++)
      wd[k] = $urandom;
    ctrl           = '0;
    ctrl.hwpe_prio = 1'b1;
    // cores hit banks 1 and 3 of the same row as the wide write
    fork
      hwpe_access(120, 1'b0, '1, wd, rw, gh);
      core_access(0, 121, 1'b0, 4'b0110, $urandom, r0, g0);
      core_access(1, 123, 1'b0, '1, $urandom, r1, g1);
    join
    if (gh < 0 || gh > g0 || gh > g1)
      report_failure("accelerator was granted after a core");
    ctrl = '0;
    hwpe_access(120, 1'b1, '0, '0, rw, gh);
    for (int k = 0; k < NB_CHAN; k++)
      check_word(model_read(120 + k), rw[k]);
    finish_test(err0);
  endtask

  initial
  begin
    void'($urandom(78989));
    rst_ni    = 1'b0;
    core_req  = '0;
    core_add  = '0;
    core_wen  = '0;
    core_be   = '0;
    core_data = '0;
    hwpe_req  = 1'b0;
    hwpe_add  = '0;
    hwpe_wen  = 1'b0;
    hwpe_be   = '0;
    hwpe_data = '0;
    ctrl      = '0;
    test_name = "reset";
    repeat (16) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    if (core_r_valid !== '0 || hwpe_r_valid !== 1'b0 || hwpe_gnt !== 1'b0)
      report_failure("outputs not idle after reset");
    next_cycle();
    core_rw();
    core_conflict();
    hwpe_rw();
    stall_escape();
    hwpe_priority();
    $display("tests ok: %0d, tests failed: %0d", pass_cnt, fail_cnt);
    if (errors == 0 && fail_cnt == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule : tb_tcdm_subsystem

// ==== flist.f ====
hdl/tcdm_pkg.sv
hdl/tcdm_mem_if.sv
hdl/tcdm_banks.sv
hdl/core_log_xbar.sv
hdl/hwpe_wide_splitter.sv
hdl/hci_shallow_interconnect.sv
hdl/tcdm_subsystem_top.sv
sim/tb_tcdm_subsystem.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the TCDM subsystem testbench with Verilator
# exit status is nonzero unless the pass line shows up in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 -f flist.f \
    --top-module tb_tcdm_subsystem -o tb_tcdm_subsystem \
  && ./obj_dir/tb_tcdm_subsystem | tee /dev/stderr | grep -Fxq "=== PASS ===" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
